// File: build.f
+incdir+logic
logic/div_pkg.sv
logic/div_unit.sv
logic/result_arbiter.sv
logic/div_cluster.sv
tests/div_cluster_asserts.sv
tests/div_cluster_tb.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/1ps --top-module div_cluster_tb \
	-f build.f -o div_cluster_sim || exit 1
out=$(./obj_dir/div_cluster_sim)
echo "$out"
echo "$out" | grep -q "All tests passed!" && exit 0 || exit 1

// File: tests/div_cluster_tb.sv
`default_nettype none

module div_cluster_tb;
	timeunit 1ns;
	timeprecision 1ps;
	import div_pkg::*;

	localparam int unsigned SEED = 32'h38039843;
	localparam int TIMEOUT_CYCLES = 70000; // Longest division is 65537 cycles
	localparam int RANDOM_OPS = 300;

	// Expected result of one division
	typedef struct packed {
		operand_t quotient;
		operand_t remainder;
		count_t cycles;
		logic div_error;
	} result_t;

	logic clock;
	logic nreset;
	logic start_0;
	operand_t dividend_0;
	operand_t divisor_0;
	logic busy_0;
	logic start_1;
	operand_t dividend_1;
	operand_t divisor_1;
	logic busy_1;
	logic result_valid;
	channel_t result_channel;
	operand_t result_quotient;
	operand_t result_remainder;
	count_t result_cycles;
	logic result_error;

	result_t expected [2]; // Set when a start is issued
	int issued [2]; // Starts per channel
	int received [2]; // Results per channel, written only by the checker
	int launched;
	int guard;
	operand_t rand_dividend;
	operand_t rand_divisor;

	div_cluster dut (.*);

	always #5 clock = ~clock;

	// Repeated subtraction gives the plain quotient, plus one load cycle
	function automatic result_t reference_divide(input operand_t a, input operand_t b);
		result_t r;
		if (b == '0) begin
			r.quotient = '1; // All ones on divide by zero
			r.remainder = a;
			r.cycles = count_t'(1); // Load only
			r.div_error = 1'b1;
		end else begin
			r.quotient = a / b;
			r.remainder = a % b;
			r.cycles = count_t'(r.quotient) + count_t'(1);
			r.div_error = 1'b0;
		end
		return r;
	endfunction

	// Idle and result already seen
	function automatic logic channel_free(input int ch);
		if (ch == 0) begin
			return (received[0] == issued[0]) && !busy_0;
		end
		return (received[1] == issued[1]) && !busy_1;
	endfunction

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Test failures found");
		$fatal(1, "Simulation stopped at first error");
	endtask

	task automatic check_operand(input string name, input operand_t got, input operand_t exp);
		if (got !== exp) begin
			abort_run($sformatf("MISMATCH at %0t: %s is %h, expected %h", $time, name, got, exp));
		end
	endtask

	task automatic check_count(input string name, input count_t got, input count_t exp);
		if (got !== exp) begin
			abort_run($sformatf("MISMATCH at %0t: %s is %0d, expected %0d", $time, name, got, exp));
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			abort_run($sformatf("MISMATCH at %0t: %s is %b, expected %b", $time, name, got, exp));
		end
	endtask

	// Ends on a falling edge with the requested channels free
	task automatic wait_ready(input logic need_0, input logic need_1);
		int n;
		n = 0;
		do begin
			@(negedge clock);
			n++;
			if (n > TIMEOUT_CYCLES) begin
				abort_run("Timeout: a channel never became free");
			end
		end while ((need_0 && !channel_free(0)) || (need_1 && !channel_free(1)));
	endtask

	// Drives a start, caller is on a falling edge
	task automatic launch(input int ch, input operand_t a, input operand_t b);
		if (ch == 0) begin
			start_0 = 1'b1;
			dividend_0 = a;
			divisor_0 = b;
		end else begin
			start_1 = 1'b1;
			dividend_1 = a;
			divisor_1 = b;
		end
		expected[ch] = reference_divide(a, b);
		issued[ch] = issued[ch] + 1;
	endtask

	task automatic run_single(input int ch, input operand_t a, input operand_t b);
		wait_ready(1'b1, 1'b1);
		launch(ch, a, b);
		@(negedge clock);
		start_0 = 1'b0;
		start_1 = 1'b0;
		wait_ready(1'b1, 1'b1);
	endtask

	// Both channels in the same cycle
	task automatic run_pair(input operand_t a0, input operand_t b0,
			input operand_t a1, input operand_t b1);
		wait_ready(1'b1, 1'b1);
		launch(0, a0, b0);
		launch(1, a1, b1);
		@(negedge clock);
		start_0 = 1'b0;
		start_1 = 1'b0;
		wait_ready(1'b1, 1'b1);
	endtask

	// Dividend kept below divisor times 64
	task automatic random_operands(output operand_t a, output operand_t b);
		int unsigned limit;
		case ($urandom % 8)
			0: b = '0;
			1, 2, 3: b = operand_t'($urandom_range(15, 1)); // Small divisors, longer loops
			default: b = operand_t'($urandom_range(65535, 1));
		endcase
		limit = (b == '0) ? 32'd65536 : 32'(b) * 32'd64;
		if (limit > 32'd65536) begin
			limit = 32'd65536;
		end
		a = operand_t'($urandom % limit);
	endtask

	// Result bus checker, sampled mid cycle
	always @(negedge clock) begin : compare_results
		int ch;
		if (nreset === 1'b1 && result_valid === 1'b1) begin
			ch = int'(result_channel);
			if (received[ch] >= issued[ch]) begin
				abort_run($sformatf("Unexpected result on channel %0d at %0t", ch, $time));
			end
			check_operand("result_quotient", result_quotient, expected[ch].quotient);
			check_operand("result_remainder", result_remainder, expected[ch].remainder);
			check_count("result_cycles", result_cycles, expected[ch].cycles);
			check_flag("result_error", result_error, expected[ch].div_error);
			received[ch] <= received[ch] + 1; // Seen by stimulus one edge later
		end
	end

	initial begin
		void'($urandom(SEED));
		clock = 1'b0;
		nreset = 1'b0;
		start_0 = 1'b0;
		dividend_0 = '0;
		divisor_0 = '0;
		start_1 = 1'b0;
		dividend_1 = '0;
		divisor_1 = '0;
		repeat (3) @(negedge clock);
		nreset = 1'b1;

		// Plain divisions on channel 0
		run_single(0, 16'd100, 16'd7);
		run_single(0, 16'd1234, 16'd10);
		run_single(0, 16'd48, 16'd48);
		run_single(0, 16'd65535, 16'd1); // Longest loop
		// Dividend below divisor, one cycle
		run_single(0, 16'd3, 16'd9);
		run_single(1, 16'd0, 16'd5);
		run_single(0, 16'd65534, 16'd65535);
		// Zero divisor
		run_single(0, 16'd1234, 16'd0);
		run_single(1, 16'd0, 16'd0);

		run_pair(16'd100, 16'd7, 16'd100, 16'd7); // Both pending in the same cycle
		run_pair(16'd5000, 16'd3, 16'd10, 16'd20); // Channel 1 done first
		run_pair(16'd9, 16'd0, 16'd900, 16'd30);

		// Start while busy must be dropped
		wait_ready(1'b1, 1'b1);
		launch(0, 16'd1000, 16'd3);
		@(negedge clock);
		start_0 = 1'b0;
		guard = 0;
		while (busy_0 !== 1'b1) begin
			@(negedge clock);
			guard++;
			if (guard > TIMEOUT_CYCLES) begin
				abort_run("Timeout: busy_0 never rose after a start");
			end
		end
		start_0 = 1'b1;
		dividend_0 = 16'd77;
		divisor_0 = 16'd5;
		@(negedge clock);
		start_0 = 1'b0;
		wait_ready(1'b1, 1'b1);
		repeat (20) @(negedge clock); // A second result would abort here

		// Random traffic on both channels
		launched = 0;
		guard = 0;
		while (launched < RANDOM_OPS) begin
			@(negedge clock);
			start_0 = 1'b0;
			start_1 = 1'b0;
			guard++;
			if (guard > TIMEOUT_CYCLES) begin
				abort_run("Timeout: random traffic did not complete");
			end
			for (int ch = 0; ch < 2; ch++) begin
				if (launched < RANDOM_OPS && channel_free(ch) && ($urandom % 4 != 0)) begin
					random_operands(rand_dividend, rand_divisor);
					launch(ch, rand_dividend, rand_divisor);
					launched++;
				end
			end
		end
		@(negedge clock);
		start_0 = 1'b0;
		start_1 = 1'b0;
		wait_ready(1'b1, 1'b1); // Every issued result has been checked

		$display("All tests passed!");
		$finish;
	end

endmodule

`default_nettype wire

// File: tests/div_cluster_asserts.sv
`default_nettype none

module div_cluster_asserts (
	input logic clock,
	input logic nreset,
	input logic grant_0,
	input logic grant_1,
	input logic pending_0,
	input logic pending_1,
	input logic busy_0,
	input logic busy_1,
	input logic result_valid
);
	timeunit 1ns;
	timeprecision 1ps;

	// At most one unit served per cycle
	one_grant: assert property (@(posedge clock) disable iff (!nreset) !(grant_0 && grant_1))
		else $error("grant_0 and grant_1 high together");

	// Every grant puts a result on the bus one cycle later
	grant_gives_valid: assert property (@(posedge clock) disable iff (!nreset)
		(grant_0 || grant_1) |=> result_valid)
		else $error("Grant not followed by result_valid");
	valid_after_grant: assert property (@(posedge clock) disable iff (!nreset)
		result_valid |-> $past(grant_0 || grant_1))
		else $error("result_valid without a grant the cycle before");

	// Granted unit drops pending on the next edge
	release_0: assert property (@(posedge clock) disable iff (!nreset) grant_0 |=> !pending_0)
		else $error("pending_0 still high after grant");
	release_1: assert property (@(posedge clock) disable iff (!nreset) grant_1 |=> !pending_1)
		else $error("pending_1 still high after grant");

	busy_while_pending_0: assert property (@(posedge clock) disable iff (!nreset)
		pending_0 |-> busy_0) else $error("busy_0 low while pending_0 high");
	busy_while_pending_1: assert property (@(posedge clock) disable iff (!nreset)
		pending_1 |-> busy_1) else $error("busy_1 low while pending_1 high");

endmodule

bind div_cluster div_cluster_asserts asserts (
	.clock(clock),
	.nreset(nreset),
	.grant_0(grant_0),
	.grant_1(grant_1),
	.pending_0(pending_0),
	.pending_1(pending_1),
	.busy_0(busy_0),
	.busy_1(busy_1),
	.result_valid(result_valid)
);

`default_nettype wire

// File: logic/div_cluster.sv
`default_nettype none

module div_cluster (
	input logic clock,
	input logic nreset,
	input logic start_0, // Channel 0 request
	input div_pkg::operand_t dividend_0,
	input div_pkg::operand_t divisor_0,
	output logic busy_0,
	input logic start_1, // Channel 1 request
	input div_pkg::operand_t dividend_1,
	input div_pkg::operand_t divisor_1,
	output logic busy_1,
	output logic result_valid, // Shared result bus
	output div_pkg::channel_t result_channel,
	output div_pkg::operand_t result_quotient,
	output div_pkg::operand_t result_remainder,
	output div_pkg::count_t result_cycles,
	output logic result_error
);
	import div_pkg::*;

	// Unit to arbiter
	logic pending_0;
	logic pending_1;
	logic grant_0;
	logic grant_1;
	operand_t quotient_0;
	operand_t quotient_1;
	operand_t remainder_0;
	operand_t remainder_1;
	count_t cycles_0;
	count_t cycles_1;
	logic div_error_0;
	logic div_error_1;

	div_unit unit_0 (
		.clock(clock),
		.nreset(nreset),
		.start(start_0),
		.dividend(dividend_0),
		.divisor(divisor_0),
		.grant(grant_0),
		.busy(busy_0),
		.pending(pending_0),
		.quotient(quotient_0),
		.remainder(remainder_0),
		.cycles(cycles_0),
		.div_error(div_error_0)
	);

	div_unit unit_1 (
		.clock(clock),
		.nreset(nreset),
		.start(start_1),
		.dividend(dividend_1),
		.divisor(divisor_1),
		.grant(grant_1),
		.busy(busy_1),
		.pending(pending_1),
		.quotient(quotient_1),
		.remainder(remainder_1),
		.cycles(cycles_1),
		.div_error(div_error_1)
	);

	// One result per cycle onto the bus
	result_arbiter arbiter (
		.clock(clock),
		.nreset(nreset),
		.pending_0(pending_0),
		.quotient_0(quotient_0),
		.remainder_0(remainder_0),
		.cycles_0(cycles_0),
		.div_error_0(div_error_0),
		.pending_1(pending_1),
		.quotient_1(quotient_1),
		.remainder_1(remainder_1),
		.cycles_1(cycles_1),
		.div_error_1(div_error_1),
		.grant_0(grant_0),
		.grant_1(grant_1),
		.result_valid(result_valid),
		.result_channel(result_channel),
		.result_quotient(result_quotient),
		.result_remainder(result_remainder),
		.result_cycles(result_cycles),
		.result_error(result_error)
	);

endmodule

`default_nettype wire

// File: logic/result_arbiter.sv
`default_nettype none

module result_arbiter (
	input logic clock,
	input logic nreset,
	input logic pending_0,
	input div_pkg::operand_t quotient_0,
	input div_pkg::operand_t remainder_0,
	input div_pkg::count_t cycles_0,
	input logic div_error_0,
	input logic pending_1,
	input div_pkg::operand_t quotient_1,
	input div_pkg::operand_t remainder_1,
	input div_pkg::count_t cycles_1,
	input logic div_error_1,
	output logic grant_0,
	output logic grant_1,
	output logic result_valid,
	output div_pkg::channel_t result_channel,
	output div_pkg::operand_t result_quotient,
	output div_pkg::operand_t result_remainder,
	output div_pkg::count_t result_cycles,
	output logic result_error
);
	import div_pkg::*;

	channel_t rr_ptr; // Channel favored this cycle
	logic last_0; // Granted last cycle
	logic last_1;
	logic elig_0;
	logic elig_1;

	// A unit just granted may still show pending
	assign elig_0 = pending_0 & ~last_0;
	assign elig_1 = pending_1 & ~last_1;

	// Round robin pick, at most one grant
	always_comb begin
		if (rr_ptr == channel_t'(0)) begin
			grant_0 = elig_0;
			grant_1 = elig_1 & ~elig_0;
		end else begin
			grant_1 = elig_1;
			grant_0 = elig_0 & ~elig_1;
		end
	end

	always_ff @(posedge clock or negedge nreset) begin
		if (!nreset) begin
			rr_ptr <= channel_t'(0); // Channel 0 first after reset
			last_0 <= 1'b0;
			last_1 <= 1'b0;
			result_valid <= 1'b0;
		end else begin
			last_0 <= grant_0;
			last_1 <= grant_1;
			result_valid <= grant_0 | grant_1; // One cycle pulse
			if (grant_0) begin
				rr_ptr <= channel_t'(1); // Pass to the other channel
			end else if (grant_1) begin
				rr_ptr <= channel_t'(0);
			end
		end
	end

	// Result bus payload
	always_ff @(posedge clock) begin
		if (grant_0) begin
			result_channel <= channel_t'(0);
			result_quotient <= quotient_0;
			result_remainder <= remainder_0;
			result_cycles <= cycles_0;
			result_error <= div_error_0;
		end else if (grant_1) begin
			result_channel <= channel_t'(1);
			result_quotient <= quotient_1;
			result_remainder <= remainder_1;
			result_cycles <= cycles_1;
			result_error <= div_error_1;
		end
	end

endmodule

`default_nettype wire

// File: logic/div_unit.sv
`default_nettype none

module div_unit (
	input logic clock,
	input logic nreset,
	input logic start, // Ignored unless idle
	input div_pkg::operand_t dividend,
	input div_pkg::operand_t divisor,
	input logic grant, // From arbiter, one cycle
	output logic busy,
	output logic pending,
	output div_pkg::operand_t quotient,
	output div_pkg::operand_t remainder,
	output div_pkg::count_t cycles,
	output logic div_error
);
	import div_pkg::*;

	div_state_t state;
	div_state_t state_next;
	operand_t divisor_r; // Latched divisor
	operand_t diff; // Remainder after one more subtraction
	logic div_zero;

	assign diff = remainder - divisor_r;
	assign div_zero = (divisor_r == '0);

	// Next state
	always_comb begin
		state_next = state;
		case (state)
			st_idle: begin
				if (start) begin
					state_next = st_load;
				end
			end
			st_load: begin
				// Zero divisor or nothing to subtract ends at once
				if (div_zero || (remainder < divisor_r)) begin
					state_next = st_hold;
				end else begin
					state_next = st_loop;
				end
			end
			st_loop: begin
				if (diff < divisor_r) begin // Last subtraction this cycle
					state_next = st_hold;
				end
			end
			st_hold: begin
				if (grant) begin
					state_next = st_idle; // Result taken by arbiter
				end
			end
			default: begin
				state_next = st_idle;
			end
		endcase
	end

	always_ff @(posedge clock or negedge nreset) begin
		if (!nreset) begin
			state <= st_idle;
		end else begin
			state <= state_next;
		end
	end

	// Datapath
	always_ff @(posedge clock) begin
		case (state)
			st_idle: begin
				if (start) begin
					remainder <= dividend; // Remainder starts as dividend
					divisor_r <= divisor;
					quotient <= '0;
					cycles <= '0;
					div_error <= 1'b0;
				end
			end
			st_load: begin
				cycles <= cycles + count_t'(1); // Load cycle counts as one
				if (div_zero) begin
					quotient <= '1; // All ones on divide by zero
					div_error <= 1'b1;
				end
			end
			st_loop: begin
				remainder <= diff;
				quotient <= quotient + operand_t'(1);
				cycles <= cycles + count_t'(1);
			end
			default: begin
				// Hold keeps the result stable
			end
		endcase
	end

	// Busy from load until the edge after grant
	assign busy = (state != st_idle);

	assign pending = (state == st_hold); // Result valid toward arbiter

endmodule

`default_nettype wire

// File: logic/div_pkg.sv
`default_nettype none

`include "div_consts.svh"

package div_pkg;

	// Dividend, divisor, quotient or remainder
	typedef logic [`DIV_WIDTH-1:0] operand_t;

	// Cycles spent on one division
	typedef logic [`DIV_COUNT_WIDTH-1:0] count_t;

	// Channel index on the result bus
	typedef logic [$clog2(`DIV_CHANNELS)-1:0] channel_t;

	// Divider FSM
	typedef enum logic [1:0] {
		st_idle, // Waiting for start
		st_load, // Operands latched, first compare
		st_loop, // One subtraction per cycle
		st_hold  // Result pending until grant
	} div_state_t;

endpackage

`default_nettype wire

// File: logic/div_consts.svh
`ifndef DIV_CONSTS_SVH
`define DIV_CONSTS_SVH

// Operand and result width, keeps the subtraction loop short enough to test
`define DIV_WIDTH 16

// Number of divider peers sharing the result bus
`define DIV_CHANNELS 2

// Cycle counter, wide enough for a full 16 bit quotient plus load
`define DIV_COUNT_WIDTH 24

`endif
